// File: axi_arb_pkg.sv
package axi_arb_pkg;

    // bus field widths
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 64;
    localparam int STRB_W  = DATA_W / 8;
    localparam int ID_W    = 4;
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    localparam logic [ID_W-1:0] IF_ID  = 4'h0;  // instruction fetch master
    localparam logic [ID_W-1:0] MEM_ID = 4'h1;  // data memory master

    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_EXOKAY = 2'b01;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;
    localparam logic [RESP_W-1:0] RESP_DECERR = 2'b11;

    localparam logic [BURST_W-1:0] BURST_FIXED = 2'b00;
    localparam logic [BURST_W-1:0] BURST_INCR  = 2'b01;
    localparam logic [BURST_W-1:0] BURST_WRAP  = 2'b10;

    // read grant FSM encoding
    localparam logic [1:0] RD_IDLE     = 2'd0;
    localparam logic [1:0] RD_IF_BUSY  = 2'd1;
    localparam logic [1:0] RD_MEM_BUSY = 2'd2;

    // write tracker FSM encoding
    localparam logic WR_IDLE = 1'b0;
    localparam logic WR_BUSY = 1'b1;

endpackage

// File: axi_read_arbiter.sv
module axi_read_arbiter (
    input  logic                                clk,
    input  logic                                rst,

    input  logic [axi_arb_pkg::ADDR_W-1:0]      if_araddr,
    input  logic [axi_arb_pkg::LEN_W-1:0]       if_arlen,
    input  logic [axi_arb_pkg::SIZE_W-1:0]      if_arsize,
    input  logic [axi_arb_pkg::BURST_W-1:0]     if_arburst,
    input  logic                                if_arvalid,
    output logic                                if_arready,
    input  logic                                if_rready,
    output logic                                if_rvalid,
    output logic [axi_arb_pkg::DATA_W-1:0]      if_rdata,
    output logic [axi_arb_pkg::RESP_W-1:0]      if_rresp,
    output logic [axi_arb_pkg::ID_W-1:0]        if_rid,
    output logic                                if_rlast,

    input  logic [axi_arb_pkg::ADDR_W-1:0]      mem_araddr,
    input  logic [axi_arb_pkg::LEN_W-1:0]       mem_arlen,
    input  logic [axi_arb_pkg::SIZE_W-1:0]      mem_arsize,
    input  logic [axi_arb_pkg::BURST_W-1:0]     mem_arburst,
    input  logic                                mem_arvalid,
    output logic                                mem_arready,
    input  logic                                mem_rready,
    output logic                                mem_rvalid,
    output logic [axi_arb_pkg::DATA_W-1:0]      mem_rdata,
    output logic [axi_arb_pkg::RESP_W-1:0]      mem_rresp,
    output logic [axi_arb_pkg::ID_W-1:0]        mem_rid,
    output logic                                mem_rlast,

    output logic                                dn_arvalid,
    output logic [axi_arb_pkg::ADDR_W-1:0]      dn_araddr,
    output logic [axi_arb_pkg::ID_W-1:0]        dn_arid,
    output logic [axi_arb_pkg::LEN_W-1:0]       dn_arlen,
    output logic [axi_arb_pkg::SIZE_W-1:0]      dn_arsize,
    output logic [axi_arb_pkg::BURST_W-1:0]     dn_arburst,
    input  logic                                dn_arready,
    input  logic                                dn_rvalid,
    input  logic [axi_arb_pkg::DATA_W-1:0]      dn_rdata,
    input  logic [axi_arb_pkg::RESP_W-1:0]      dn_rresp,
    input  logic [axi_arb_pkg::ID_W-1:0]        dn_rid,
    input  logic                                dn_rlast,
    output logic                                dn_rready
);

    logic [1:0] state;
    logic       pick_if;  // fetch wins whenever it is requesting
    logic       ar_fire;
    logic       r_done;

    assign pick_if = if_arvalid;
    assign ar_fire = dn_arvalid & dn_arready;
    assign r_done  = dn_rvalid & dn_rready & dn_rlast;  // burst ends on the accepted last beat

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= axi_arb_pkg::RD_IDLE;
        end else begin
            case (state)
                axi_arb_pkg::RD_IDLE: begin
                    if (ar_fire) begin
                        state <= pick_if ? axi_arb_pkg::RD_IF_BUSY : axi_arb_pkg::RD_MEM_BUSY;
                    end
                end
                axi_arb_pkg::RD_IF_BUSY,
                axi_arb_pkg::RD_MEM_BUSY: begin
                    if (r_done) begin
                        state <= axi_arb_pkg::RD_IDLE;
                    end
                end
                default: begin
                    state <= axi_arb_pkg::RD_IDLE;
                end
            endcase
        end
    end

    // address payload follows the winner, valid gates it
    assign dn_araddr  = pick_if ? if_araddr : mem_araddr;
    assign dn_arlen   = pick_if ? if_arlen : mem_arlen;
    assign dn_arsize  = pick_if ? if_arsize : mem_arsize;
    assign dn_arburst = pick_if ? if_arburst : mem_arburst;
    assign dn_arid    = pick_if ? axi_arb_pkg::IF_ID : axi_arb_pkg::MEM_ID;

    always_comb begin
        dn_arvalid  = 1'b0;
        if_arready  = 1'b0;
        mem_arready = 1'b0;
        if (state == axi_arb_pkg::RD_IDLE) begin
            dn_arvalid  = if_arvalid | mem_arvalid;
            if_arready  = pick_if & dn_arready;
            mem_arready = ~pick_if & dn_arready;  // loser stays stalled
        end
    end

    always_comb begin
        if_rvalid  = 1'b0;
        if_rdata   = '0;
        if_rresp   = '0;
        if_rid     = '0;
        if_rlast   = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        mem_rresp  = '0;
        mem_rid    = '0;
        mem_rlast  = 1'b0;
        dn_rready  = 1'b0;
        case (state)
            axi_arb_pkg::RD_IF_BUSY: begin
                if_rvalid = dn_rvalid;
                if_rdata  = dn_rdata;
                if_rresp  = dn_rresp;
                if_rid    = dn_rid;
                if_rlast  = dn_rlast;
                dn_rready = if_rready;
            end
            axi_arb_pkg::RD_MEM_BUSY: begin
                mem_rvalid = dn_rvalid;
                mem_rdata  = dn_rdata;
                mem_rresp  = dn_rresp;
                mem_rid    = dn_rid;
                mem_rlast  = dn_rlast;
                dn_rready  = mem_rready;
            end
            default: begin
                dn_rready = 1'b0;  // nothing outstanding so no beat is taken
            end
        endcase
    end

endmodule

// File: axi_write_tracker.sv
module axi_write_tracker (
    input  logic                                clk,
    input  logic                                rst,

    input  logic [axi_arb_pkg::ADDR_W-1:0]      mem_awaddr,
    input  logic [axi_arb_pkg::LEN_W-1:0]       mem_awlen,
    input  logic [axi_arb_pkg::SIZE_W-1:0]      mem_awsize,
    input  logic [axi_arb_pkg::BURST_W-1:0]     mem_awburst,
    input  logic                                mem_awvalid,
    output logic                                mem_awready,
    input  logic [axi_arb_pkg::DATA_W-1:0]      mem_wdata,
    input  logic [axi_arb_pkg::STRB_W-1:0]      mem_wstrb,
    input  logic                                mem_wlast,
    input  logic                                mem_wvalid,
    output logic                                mem_wready,
    input  logic                                mem_bready,
    output logic                                mem_bvalid,
    output logic [axi_arb_pkg::RESP_W-1:0]      mem_bresp,
    output logic [axi_arb_pkg::ID_W-1:0]        mem_bid,

    output logic                                dn_awvalid,
    output logic [axi_arb_pkg::ADDR_W-1:0]      dn_awaddr,
    output logic [axi_arb_pkg::ID_W-1:0]        dn_awid,
    output logic [axi_arb_pkg::LEN_W-1:0]       dn_awlen,
    output logic [axi_arb_pkg::SIZE_W-1:0]      dn_awsize,
    output logic [axi_arb_pkg::BURST_W-1:0]     dn_awburst,
    input  logic                                dn_awready,
    output logic                                dn_wvalid,
    output logic [axi_arb_pkg::DATA_W-1:0]      dn_wdata,
    output logic [axi_arb_pkg::STRB_W-1:0]      dn_wstrb,
    output logic                                dn_wlast,
    input  logic                                dn_wready,
    input  logic                                dn_bvalid,
    input  logic [axi_arb_pkg::RESP_W-1:0]      dn_bresp,
    input  logic [axi_arb_pkg::ID_W-1:0]        dn_bid,
    output logic                                dn_bready
);

    logic state;
    logic aw_fire;
    logic b_fire;

    assign aw_fire = dn_awvalid & dn_awready;
    assign b_fire  = dn_bvalid & dn_bready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= axi_arb_pkg::WR_IDLE;
        end else begin
            case (state)
                axi_arb_pkg::WR_IDLE: begin
                    if (aw_fire) begin
                        state <= axi_arb_pkg::WR_BUSY;
                    end
                end
                default: begin
                    if (b_fire) begin
                        state <= axi_arb_pkg::WR_IDLE;  // any response code closes the write
                    end
                end
            endcase
        end
    end

    // only one write burst may be outstanding
    assign dn_awvalid  = (state == axi_arb_pkg::WR_IDLE) & mem_awvalid;
    assign mem_awready = (state == axi_arb_pkg::WR_IDLE) & dn_awready;
    assign dn_awid     = axi_arb_pkg::MEM_ID;
    assign dn_awaddr   = mem_awaddr;
    assign dn_awlen    = mem_awlen;
    assign dn_awsize   = mem_awsize;
    assign dn_awburst  = mem_awburst;

    assign dn_wvalid  = mem_wvalid;
    assign dn_wdata   = mem_wdata;
    assign dn_wstrb   = mem_wstrb;
    assign dn_wlast   = mem_wlast;
    assign mem_wready = (state == axi_arb_pkg::WR_BUSY) & dn_wready;  // no W beat ahead of its AW

    assign dn_bready  = mem_bready;
    assign mem_bvalid = (state == axi_arb_pkg::WR_BUSY) & dn_bvalid;
    assign mem_bresp  = dn_bresp;
    assign mem_bid    = dn_bid;

endmodule

// File: axi_master_arbiter.sv
module axi_master_arbiter (
    input  logic                                clk,
    input  logic                                rst,

    input  logic [axi_arb_pkg::ADDR_W-1:0]      if_araddr,
    input  logic [axi_arb_pkg::LEN_W-1:0]       if_arlen,
    input  logic [axi_arb_pkg::SIZE_W-1:0]      if_arsize,
    input  logic [axi_arb_pkg::BURST_W-1:0]     if_arburst,
    input  logic                                if_arvalid,
    output logic                                if_arready,
    output logic                                if_rvalid,
    output logic [axi_arb_pkg::DATA_W-1:0]      if_rdata,
    output logic [axi_arb_pkg::RESP_W-1:0]      if_rresp,
    output logic [axi_arb_pkg::ID_W-1:0]        if_rid,
    output logic                                if_rlast,
    input  logic                                if_rready,

    input  logic [axi_arb_pkg::ADDR_W-1:0]      mem_araddr,
    input  logic [axi_arb_pkg::LEN_W-1:0]       mem_arlen,
    input  logic [axi_arb_pkg::SIZE_W-1:0]      mem_arsize,
    input  logic [axi_arb_pkg::BURST_W-1:0]     mem_arburst,
    input  logic                                mem_arvalid,
    output logic                                mem_arready,
    output logic                                mem_rvalid,
    output logic [axi_arb_pkg::DATA_W-1:0]      mem_rdata,
    output logic [axi_arb_pkg::RESP_W-1:0]      mem_rresp,
    output logic [axi_arb_pkg::ID_W-1:0]        mem_rid,
    output logic                                mem_rlast,
    input  logic                                mem_rready,

    input  logic [axi_arb_pkg::ADDR_W-1:0]      mem_awaddr,
    input  logic [axi_arb_pkg::LEN_W-1:0]       mem_awlen,
    input  logic [axi_arb_pkg::SIZE_W-1:0]      mem_awsize,
    input  logic [axi_arb_pkg::BURST_W-1:0]     mem_awburst,
    input  logic                                mem_awvalid,
    output logic                                mem_awready,
    input  logic [axi_arb_pkg::DATA_W-1:0]      mem_wdata,
    input  logic [axi_arb_pkg::STRB_W-1:0]      mem_wstrb,
    input  logic                                mem_wlast,
    input  logic                                mem_wvalid,
    output logic                                mem_wready,
    output logic                                mem_bvalid,
    output logic [axi_arb_pkg::RESP_W-1:0]      mem_bresp,
    output logic [axi_arb_pkg::ID_W-1:0]        mem_bid,
    input  logic                                mem_bready,

    output logic                                dn_arvalid,
    output logic [axi_arb_pkg::ADDR_W-1:0]      dn_araddr,
    output logic [axi_arb_pkg::ID_W-1:0]        dn_arid,
    output logic [axi_arb_pkg::LEN_W-1:0]       dn_arlen,
    output logic [axi_arb_pkg::SIZE_W-1:0]      dn_arsize,
    output logic [axi_arb_pkg::BURST_W-1:0]     dn_arburst,
    input  logic                                dn_arready,
    input  logic                                dn_rvalid,
    input  logic [axi_arb_pkg::DATA_W-1:0]      dn_rdata,
    input  logic [axi_arb_pkg::RESP_W-1:0]      dn_rresp,
    input  logic [axi_arb_pkg::ID_W-1:0]        dn_rid,
    input  logic                                dn_rlast,
    output logic                                dn_rready,

    output logic                                dn_awvalid,
    output logic [axi_arb_pkg::ADDR_W-1:0]      dn_awaddr,
    output logic [axi_arb_pkg::ID_W-1:0]        dn_awid,
    output logic [axi_arb_pkg::LEN_W-1:0]       dn_awlen,
    output logic [axi_arb_pkg::SIZE_W-1:0]      dn_awsize,
    output logic [axi_arb_pkg::BURST_W-1:0]     dn_awburst,
    input  logic                                dn_awready,
    output logic                                dn_wvalid,
    output logic [axi_arb_pkg::DATA_W-1:0]      dn_wdata,
    output logic [axi_arb_pkg::STRB_W-1:0]      dn_wstrb,
    output logic                                dn_wlast,
    input  logic                                dn_wready,
    input  logic                                dn_bvalid,
    input  logic [axi_arb_pkg::RESP_W-1:0]      dn_bresp,
    input  logic [axi_arb_pkg::ID_W-1:0]        dn_bid,
    output logic                                dn_bready
);

    // port names match one to one, the read and write paths share nothing
    axi_read_arbiter u_read (
        .*
    );

    axi_write_tracker u_write (
        .*
    );

endmodule

// File: tb_axi_slave_model.sv
module tb_axi_slave_model (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [31:0]                         rnd,
    input  logic                                dn_arvalid,
    input  logic [axi_arb_pkg::ADDR_W-1:0]      dn_araddr,
    input  logic [axi_arb_pkg::ID_W-1:0]        dn_arid,
    input  logic [axi_arb_pkg::LEN_W-1:0]       dn_arlen,
    output logic                                dn_arready,
    output logic                                dn_rvalid,
    output logic [axi_arb_pkg::DATA_W-1:0]      dn_rdata,
    output logic [axi_arb_pkg::RESP_W-1:0]      dn_rresp,
    output logic [axi_arb_pkg::ID_W-1:0]        dn_rid,
    output logic                                dn_rlast,
    input  logic                                dn_rready,
    input  logic                                dn_awvalid,
    input  logic [axi_arb_pkg::ID_W-1:0]        dn_awid,
    output logic                                dn_awready,
    input  logic                                dn_wvalid,
    input  logic                                dn_wlast,
    output logic                                dn_wready,
    output logic                                dn_bvalid,
    output logic [axi_arb_pkg::RESP_W-1:0]      dn_bresp,
    output logic [axi_arb_pkg::ID_W-1:0]        dn_bid,
    input  logic                                dn_bready,
    output logic [7:0]                          w_beats
);

    logic                              rd_busy;
    logic [axi_arb_pkg::ADDR_W-1:0]    rd_addr;
    logic [axi_arb_pkg::LEN_W-1:0]     rd_len;
    logic [7:0]                        rd_beat;
    logic                              wr_busy;
    logic                              b_pend;
    logic [axi_arb_pkg::ID_W-1:0]      wr_id;

    // beat k carries the burst address on top and k below
    assign dn_rdata = {rd_addr, 24'd0, rd_beat};
    assign dn_rlast = (rd_beat == rd_len);
    assign dn_rresp = axi_arb_pkg::RESP_OKAY;
    assign dn_bresp = axi_arb_pkg::RESP_OKAY;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_busy    <= 1'b0;
            rd_addr    <= '0;
            rd_len     <= '0;
            rd_beat    <= '0;
            dn_rid     <= '0;
            dn_arready <= 1'b0;
            dn_rvalid  <= 1'b0;
        end else if (!rd_busy) begin
            if (dn_arvalid && dn_arready) begin
                rd_busy    <= 1'b1;
                rd_addr    <= dn_araddr;
                rd_len     <= dn_arlen;
                rd_beat    <= '0;
                dn_rid     <= dn_arid;
                dn_arready <= 1'b0;
                dn_rvalid  <= rnd[0];
            end else begin
                dn_arready <= rnd[1];
            end
        end else if (dn_rvalid && dn_rready) begin
            if (dn_rlast) begin
                rd_busy   <= 1'b0;
                dn_rvalid <= 1'b0;
            end else begin
                rd_beat   <= rd_beat + 8'd1;
                dn_rvalid <= rnd[0];
            end
        end else if (!dn_rvalid) begin
            dn_rvalid <= rnd[0];  // a raised valid is held until taken
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_busy    <= 1'b0;
            b_pend     <= 1'b0;
            wr_id      <= '0;
            w_beats    <= '0;
            dn_awready <= 1'b0;
            dn_wready  <= 1'b0;
            dn_bvalid  <= 1'b0;
            dn_bid     <= '0;
        end else if (!wr_busy) begin
            if (dn_awvalid && dn_awready) begin
                wr_busy    <= 1'b1;
                wr_id      <= dn_awid;
                w_beats    <= '0;
                dn_awready <= 1'b0;
                dn_wready  <= rnd[3];
            end else begin
                dn_awready <= rnd[2];
            end
        end else if (dn_bvalid) begin
            if (dn_bready) begin
                dn_bvalid <= 1'b0;
                b_pend    <= 1'b0;
                wr_busy   <= 1'b0;
            end
        end else if (b_pend) begin
            dn_bvalid <= rnd[4];
            dn_bid    <= wr_id;
        end else if (dn_wvalid && dn_wready) begin
            w_beats <= w_beats + 8'd1;
            if (dn_wlast) begin
                dn_wready <= 1'b0;
                b_pend    <= 1'b1;
            end else begin
                dn_wready <= rnd[3];
            end
        end else begin
            dn_wready <= rnd[3];
        end
    end

endmodule

// File: tb_axi_master_arbiter.sv
module tb_axi_master_arbiter;

    localparam int n_writes   = 3;
    localparam int n_rand     = 16;
    localparam int n_bursts   = 4 + n_writes + 2 * n_rand;
    localparam int wait_limit = 400;

    logic clk, rst;
    logic [31:0] rnd;
    logic [7:0]  w_beats;
    logic [axi_arb_pkg::ADDR_W-1:0]  if_araddr, mem_araddr, mem_awaddr, dn_araddr, dn_awaddr;
    logic [axi_arb_pkg::LEN_W-1:0]   if_arlen, mem_arlen, mem_awlen, dn_arlen, dn_awlen;
    logic [axi_arb_pkg::SIZE_W-1:0]  if_arsize, mem_arsize, mem_awsize, dn_arsize, dn_awsize;
    logic [axi_arb_pkg::BURST_W-1:0] if_arburst, mem_arburst, mem_awburst, dn_arburst, dn_awburst;
    logic [axi_arb_pkg::DATA_W-1:0]  if_rdata, mem_rdata, mem_wdata, dn_rdata, dn_wdata;
    logic [axi_arb_pkg::STRB_W-1:0]  mem_wstrb, dn_wstrb;
    logic [axi_arb_pkg::RESP_W-1:0]  if_rresp, mem_rresp, mem_bresp, dn_rresp, dn_bresp;
    logic [axi_arb_pkg::ID_W-1:0]    if_rid, mem_rid, mem_bid, dn_arid, dn_rid, dn_awid, dn_bid;
    logic if_arvalid, if_arready, if_rvalid, if_rlast, if_rready;
    logic mem_arvalid, mem_arready, mem_rvalid, mem_rlast, mem_rready;
    logic mem_awvalid, mem_awready, mem_wlast, mem_wvalid, mem_wready, mem_bvalid, mem_bready;
    logic dn_arvalid, dn_arready, dn_rvalid, dn_rlast, dn_rready;
    logic dn_awvalid, dn_awready, dn_wvalid, dn_wlast, dn_wready, dn_bvalid, dn_bready;

    int errors, failures, ar_count, wr_done, dn_w_idx;
    int issued [2];  // index 0 is the fetch port, 1 the data port
    int done_cnt [2];
    int beat [2];
    int got [2];
    int sent [2];
    int expect_beats [2];
    logic [31:0] req_addr [2];
    logic [7:0]  req_len [2];
    logic [3:0]  ar_ids [64];
    logic [31:0] wr_addr;
    logic [7:0]  wr_len;
    logic rd_open, aw_open;

    axi_master_arbiter i_dut (.*);
    tb_axi_slave_model i_slave (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [63:0] read_word(input logic [31:0] addr, input logic [31:0] k);
        return {addr, k};
    endfunction

    function automatic logic [63:0] write_word(input logic [31:0] addr, input logic [31:0] k);
        return {~addr, 32'hc0de_0000 + k};
    endfunction

    function automatic logic [7:0] write_strb(input int k);
        return 8'hff >> (k % 8);
    endfunction

    task automatic report_error(input string msg);
        errors = errors + 1;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        failures = failures + 1;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic check_beat(input int p, input logic [63:0] data, input logic [1:0] resp,
                              input logic [3:0] id, input logic last);
        logic [3:0] want_id;
        want_id = (p == 0) ? axi_arb_pkg::IF_ID : axi_arb_pkg::MEM_ID;
        assert (data == read_word(req_addr[p], beat[p]))
        else report_error($sformatf("port %0d beat %0d bad data %h", p, beat[p], data));
        assert (id == want_id && resp == axi_arb_pkg::RESP_OKAY)
        else report_error($sformatf("port %0d bad rid %0d or rresp %0d", p, id, resp));
        assert (last == (beat[p] == req_len[p]))
        else report_error($sformatf("port %0d rlast wrong on beat %0d", p, beat[p]));
    endtask

    task automatic start_read(input int p, input logic [31:0] addr, input logic [7:0] len);
        req_addr[p] = addr;
        req_len[p] = len;
        issued[p] = issued[p] + 1;
        expect_beats[p] = expect_beats[p] + len + 1;
        if (p == 0) begin
            if_araddr  <= addr;
            if_arlen   <= len;
            if_arburst <= axi_arb_pkg::BURST_INCR;
            if_arvalid <= 1'b1;
        end else begin
            mem_araddr  <= addr;
            mem_arlen   <= len;
            mem_arburst <= axi_arb_pkg::BURST_WRAP;
            mem_arvalid <= 1'b1;
        end
    endtask

    task automatic wait_reads_idle();
        int n;
        n = 0;
        while ((done_cnt[0] != issued[0] || done_cnt[1] != issued[1]) && n < wait_limit) begin
            @(posedge clk);
            n = n + 1;
        end
        if (done_cnt[0] != issued[0] || done_cnt[1] != issued[1])
            report_failure("read bursts did not complete in time");
    endtask

    task automatic write_burst(input logic [31:0] addr, input logic [7:0] len);
        int k;
        int n;
        int target;
        k = 0;
        n = 0;
        target = wr_done + 1;
        wr_addr = addr;
        wr_len = len;
        mem_awaddr  <= addr;
        mem_awlen   <= len;
        mem_awburst <= axi_arb_pkg::BURST_INCR;
        mem_awvalid <= 1'b1;
        mem_wdata   <= write_word(addr, 0);
        mem_wstrb   <= write_strb(0);
        mem_wlast   <= (len == 0);
        mem_wvalid  <= 1'b1;  // W is offered together with AW
        while (wr_done != target && n < wait_limit) begin
            @(posedge clk);
            n = n + 1;
            mem_bready <= rnd[11];
            if (mem_awvalid && mem_awready)
                mem_awvalid <= 1'b0;
            if (mem_wvalid && mem_wready) begin
                k = k + 1;
                mem_wdata  <= write_word(addr, k);
                mem_wstrb  <= write_strb(k);
                mem_wlast  <= (k == len);
                mem_wvalid <= (k <= len) && rnd[10];
            end else if (!mem_wvalid && k <= len) begin
                mem_wvalid <= rnd[10];
            end
        end
        if (wr_done != target)
            report_failure("write burst did not complete in time");
    endtask

    always @(posedge clk) begin
        rnd <= xorshift(rnd);
        if_rready <= rnd[8];
        mem_rready <= rnd[9];
        if (if_arvalid && if_arready)
            if_arvalid <= 1'b0;
        if (mem_arvalid && mem_arready)
            mem_arvalid <= 1'b0;
    end

    always @(posedge clk) begin
        if (!rst) begin
            assert (!(if_arvalid && mem_arready)) else report_error("mem_arready high while fetch requests");
            assert (!(rd_open && (dn_arvalid || if_arready || mem_arready)))
            else report_error("address channel open during a read burst");
            if (dn_arvalid && dn_arready) begin
                rd_open <= 1'b1;
                ar_ids[ar_count] <= dn_arid;
                ar_count <= ar_count + 1;
                if (if_arvalid) begin
                    assert (dn_arid == axi_arb_pkg::IF_ID && dn_araddr == req_addr[0])
                    else report_error("fetch request not forwarded downstream");
                    assert (dn_arlen == req_len[0] && dn_arsize == 3'd3
                            && dn_arburst == axi_arb_pkg::BURST_INCR)
                    else report_error("fetch burst fields not forwarded downstream");
                end else begin
                    assert (dn_arid == axi_arb_pkg::MEM_ID && dn_araddr == req_addr[1])
                    else report_error("data request not forwarded downstream");
                    assert (dn_arlen == req_len[1] && dn_arsize == 3'd2
                            && dn_arburst == axi_arb_pkg::BURST_WRAP)
                    else report_error("data burst fields not forwarded downstream");
                end
            end
            if (dn_rvalid && dn_rid == axi_arb_pkg::IF_ID) begin
                assert (if_rvalid && !mem_rvalid) else report_error("fetch beat routed wrong");
            end else if (dn_rvalid) begin
                assert (mem_rvalid && !if_rvalid) else report_error("data beat routed wrong");
            end else begin
                assert (!if_rvalid && !mem_rvalid) else report_error("rvalid without a beat");
            end
            if (dn_rvalid && dn_rready) begin
                if (dn_rlast)
                    rd_open <= 1'b0;
                if (dn_rid == axi_arb_pkg::IF_ID)
                    sent[0] <= sent[0] + 1;
                else
                    sent[1] <= sent[1] + 1;
            end
            if (if_rvalid && if_rready) begin
                check_beat(0, if_rdata, if_rresp, if_rid, if_rlast);
                got[0] <= got[0] + 1;
                beat[0] <= if_rlast ? 0 : beat[0] + 1;
                if (if_rlast)
                    done_cnt[0] <= done_cnt[0] + 1;
            end
            if (mem_rvalid && mem_rready) begin
                check_beat(1, mem_rdata, mem_rresp, mem_rid, mem_rlast);
                got[1] <= got[1] + 1;
                beat[1] <= mem_rlast ? 0 : beat[1] + 1;
                if (mem_rlast)
                    done_cnt[1] <= done_cnt[1] + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            assert (!(mem_wready && !aw_open)) else report_error("mem_wready high before the AW transfer");
            assert (!(aw_open && dn_awvalid)) else report_error("second AW issued during a write");
            if (mem_awvalid && mem_awready) begin
                aw_open <= 1'b1;
                dn_w_idx <= 0;
                assert (dn_awid == axi_arb_pkg::MEM_ID && dn_awaddr == wr_addr && dn_awlen == wr_len)
                else report_error("write address not forwarded with MEM_ID");
                assert (dn_awsize == 3'd3 && dn_awburst == axi_arb_pkg::BURST_INCR)
                else report_error("write burst fields not forwarded downstream");
            end
            if (dn_wvalid && dn_wready) begin
                assert (dn_wdata == write_word(wr_addr, dn_w_idx) && dn_wlast == (dn_w_idx == wr_len))
                else report_error($sformatf("write beat %0d changed on the way", dn_w_idx));
                assert (dn_wstrb == write_strb(dn_w_idx))
                else report_error($sformatf("write strobe %0d changed on the way", dn_w_idx));
                dn_w_idx <= dn_w_idx + 1;
            end
            if (mem_bvalid && mem_bready) begin
                aw_open <= 1'b0;
                wr_done <= wr_done + 1;
                assert (mem_bid == axi_arb_pkg::MEM_ID && mem_bresp == axi_arb_pkg::RESP_OKAY)
                else report_error("bad write response");
                assert (w_beats == wr_len + 1) else report_error("wrong count of write beats");
            end
        end
    end

    initial begin
        repeat (10 + 40 * n_bursts + 200) @(posedge clk);
        report_failure("watchdog expired before the tests finished");
        $display("errors: %0d  failures: %0d", errors, failures);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int i;
        int first;
        clk = 1'b0;
        rnd = 32'hb888;
        errors = 0;
        failures = 0;
        ar_count = 0;
        wr_done = 0;
        dn_w_idx = 0;
        rd_open = 1'b0;
        aw_open = 1'b0;
        wr_addr = '0;
        wr_len = '0;
        for (i = 0; i < 2; i = i + 1) begin
            issued[i] = 0;
            done_cnt[i] = 0;
            beat[i] = 0;
            got[i] = 0;
            sent[i] = 0;
            expect_beats[i] = 0;
            req_addr[i] = '0;
            req_len[i] = '0;
        end
        rst <= 1'b1;
        if_araddr <= '0;
        if_arlen <= '0;
        if_arsize <= 3'd3;
        if_arburst <= axi_arb_pkg::BURST_INCR;
        if_arvalid <= 1'b0;
        if_rready <= 1'b0;
        mem_araddr <= '0;
        mem_arlen <= '0;
        mem_arsize <= 3'd2;  // differs from fetch so the size mux is seen
        mem_arburst <= axi_arb_pkg::BURST_INCR;
        mem_arvalid <= 1'b0;
        mem_rready <= 1'b0;
        mem_awaddr <= '0;
        mem_awlen <= '0;
        mem_awsize <= 3'd3;
        mem_awburst <= axi_arb_pkg::BURST_INCR;
        mem_awvalid <= 1'b0;
        mem_wdata <= '0;
        mem_wstrb <= '1;
        mem_wlast <= 1'b0;
        mem_wvalid <= 1'b0;
        mem_bready <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!if_rvalid && !mem_rvalid && !mem_bvalid && !mem_wready)
        else report_error("valid or ready outputs high after reset");

        start_read(0, 32'h0000_1000, 8'd7);
        wait_reads_idle();
        start_read(1, 32'h0000_2040, 8'd3);
        wait_reads_idle();

        // both masters in the same cycle, fetch has priority
        first = ar_count;
        start_read(0, 32'h0000_3000, 8'd5);
        start_read(1, 32'h0000_4000, 8'd2);
        wait_reads_idle();
        assert (ar_ids[first] == axi_arb_pkg::IF_ID && ar_ids[first + 1] == axi_arb_pkg::MEM_ID)
        else report_error("simultaneous requests not served fetch first");

        for (i = 0; i < n_writes; i = i + 1)
            write_burst(32'h0000_8000 + 32'h100 * i, 8'd1 + 8'd3 * i[7:0]);

        // rnd[17:16] picks fetch only, data only or both
        for (i = 0; i < n_rand; i = i + 1) begin
            if (rnd[17:16] != 2'd1)
                start_read(0, {16'h0010, rnd[31:20], 4'h0}, {5'd0, rnd[14:12]});
            if (rnd[17:16] != 2'd0)
                start_read(1, {16'h0020, rnd[27:16], 4'h0}, {5'd0, rnd[26:24]});
            wait_reads_idle();
        end

        assert (got[0] == sent[0] && got[1] == sent[1])
        else report_error("beat counts differ between slave and masters");
        assert (got[0] == expect_beats[0] && got[1] == expect_beats[1])
        else report_error("beat counts differ from the requested burst lengths");
        $display("errors: %0d  failures: %0d", errors, failures);
        if (errors == 0 && failures == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: all.f
axi_arb_pkg.sv
axi_read_arbiter.sv
axi_write_tracker.sv
axi_master_arbiter.sv
tb_axi_slave_model.sv
tb_axi_master_arbiter.sv
